// ==== common/video_defs.svh ====
// Raster timing and window bounds for the video engine, included by the RTL and the testbench
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// counter width shared by the line and frame counters
`define VIDEO_CNT_W          9

// one line is 448 clocks, one frame 320 lines
`define VIDEO_HPERIOD        448
`define VIDEO_VPERIOD        320

// sync pulses, inclusive bounds
`define VIDEO_HSYNC_BEG      10
`define VIDEO_HSYNC_END      42
`define VIDEO_VSYNC_BEG      8
`define VIDEO_VSYNC_END      10

// blanking covers counts 0..HBLNK_END and lines 0..VBLNK_END
`define VIDEO_HBLNK_END      88
`define VIDEO_VBLNK_END      31

// active bitmap window, 256 x 192, inclusive bounds
`define VIDEO_HPIX_BEG       136
`define VIDEO_HPIX_END       391
`define VIDEO_VPIX_BEG       80
`define VIDEO_VPIX_END       271

// fetch side
`define VIDEO_FETCH_LEAD     24
`define VIDEO_FIFO_DEPTH     4
`define VIDEO_WORDS_PER_LINE 16

`endif

// ==== common/video_pkg.sv ====
// Shared types of the video engine, imported by the fetch unit, the renderer and the testbench
package video_pkg;

	// one pixel color
	typedef logic [3:0] color_t;

	// one bitmap word, 16 pixels, msb leftmost
	typedef logic [15:0] vram_word_t;

	// word address, row * 16 + word
	typedef logic [11:0] vram_addr_t;

	// per-line fetch sequence
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		FETCH = 2'd1,
		DONE  = 2'd2
	} fetch_state_e;

	// where a pixel's color comes from
	typedef enum logic [1:0] {
		BORDER = 2'd0,
		PAPER  = 2'd1,
		INK    = 2'd2
	} pix_src_e;

endpackage

// ==== rtl/video_sync.sv ====
// Raster timing generator for counters, syncs, blanking and window flags, used inside video_top
`include "video_defs.svh"

module video_sync (
	input  logic       clk,
	input  logic       arst_n,
	input  logic [8:0] int_line,
	input  logic [8:0] int_col,
	output logic       hsync,
	output logic       vsync,
	output logic       csync,
	output logic       blank_raw,
	output logic       hvpix,
	output logic       fetch_win,
	output logic       line_start,
	output logic       frame_start,
	output logic       int_start,
	output logic [7:0] lcount
);

	localparam int W = `VIDEO_CNT_W;

	logic [W-1:0] hcount;
	logic [W-1:0] vcount;
	logic         hs;
	logic         vs;
	logic         hblank;
	logic         vblank;
	logic         hpix;
	logic         vpix;

	// horizontal counter, wraps at end of line
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			hcount <= '0;
		else if (line_start)
			hcount <= '0;
		else
			hcount <= hcount + 1'b1;
	end

	// vertical counter steps once per line
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			vcount <= '0;
		else if (frame_start)
			vcount <= '0;
		else if (line_start)
			vcount <= vcount + 1'b1;
	end

	assign line_start  = (hcount == W'(`VIDEO_HPERIOD - 1));
	assign frame_start = line_start && (vcount == W'(`VIDEO_VPERIOD - 1));

	// raw sync windows are active high here
	assign hs = (hcount >= W'(`VIDEO_HSYNC_BEG)) && (hcount <= W'(`VIDEO_HSYNC_END));
	assign vs = (vcount >= W'(`VIDEO_VSYNC_BEG)) && (vcount <= W'(`VIDEO_VSYNC_END));

	assign hblank    = (hcount <= W'(`VIDEO_HBLNK_END));
	assign vblank    = (vcount <= W'(`VIDEO_VBLNK_END));
	assign blank_raw = hblank || vblank;

	// bitmap window
	assign hpix  = (hcount >= W'(`VIDEO_HPIX_BEG)) && (hcount <= W'(`VIDEO_HPIX_END));
	assign vpix  = (vcount >= W'(`VIDEO_VPIX_BEG)) && (vcount <= W'(`VIDEO_VPIX_END));
	assign hvpix = hpix && vpix;

	// opens early so the word fifo is primed before the first pixel
	assign fetch_win = vpix &&
		(hcount >= W'(`VIDEO_HPIX_BEG - `VIDEO_FETCH_LEAD)) &&
		(hcount <= W'(`VIDEO_HPIX_END));

	// bitmap row is only meaningful while vpix is set
	assign lcount = 8'(vcount - W'(`VIDEO_VPIX_BEG));

	assign int_start = (hcount == int_col) && (vcount == int_line);

	// syncs are active low and one clock behind the counts
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			csync <= 1'b1;
		end
		else
		begin
			hsync <= ~hs;
			vsync <= ~vs;
			csync <= ~(hs ^ vs);
		end
	end

endmodule

// ==== rtl/video_fetch.sv ====
// Bitmap fetch unit in video_top that reads one word per 16 pixels, paced by FIFO credits
`include "video_defs.svh"

module video_fetch (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  gfx_en,
	input  logic                  fetch_win,
	input  logic                  line_start,
	input  logic [7:0]            lcount,
	input  logic                  credit_ret,
	output logic                  rd_req,
	output video_pkg::vram_addr_t rd_addr
);
	import video_pkg::*;

	localparam int DEPTH = `VIDEO_FIFO_DEPTH;
	localparam int WORDS = `VIDEO_WORDS_PER_LINE;

	fetch_state_e state;
	logic [4:0]   wcnt;
	logic [2:0]   credits;
	logic         issue;

	// a free credit turns into a request on the next clock
	assign issue = (state == FETCH) && fetch_win && (credits != '0) && (wcnt < 5'(WORDS));

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= IDLE;
			wcnt  <= '0;
		end
		else if (line_start)
		begin
			state <= IDLE;
			wcnt  <= '0;
		end
		else
		begin
			case (state)
				IDLE:
					if (gfx_en && fetch_win)
						state <= FETCH;
				FETCH:
					if (wcnt == 5'(WORDS))
						state <= DONE;
				default:
					state <= DONE;
			endcase
			if (issue)
				wcnt <= wcnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			rd_req <= 1'b0;
		else
			rd_req <= issue;
	end

	// row * 16 + word
	always_ff @(posedge clk)
	begin
		if (issue)
			rd_addr <= {lcount, wcnt[3:0]};
	end

	// credits come back as words leave the fifo
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			credits <= 3'(DEPTH);
		else if (issue && !credit_ret)
			credits <= credits - 1'b1;
		else if (credit_ret && !issue)
			credits <= credits + 1'b1;
	end

	a_credit_max: assert property (@(posedge clk) disable iff (!arst_n)
		credits <= 3'(DEPTH));

endmodule

// ==== rtl/pixel_render.sv ====
// Pixel renderer: buffers returned words, serializes them msb first and picks ink, paper or border
`include "video_defs.svh"

module pixel_render (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  rd_valid,
	input  video_pkg::vram_word_t rd_data,
	input  logic                  hvpix,
	input  logic                  blank_raw,
	input  logic                  gfx_en,
	input  video_pkg::color_t     ink,
	input  video_pkg::color_t     paper,
	input  video_pkg::color_t     border,
	output logic                  credit_ret,
	output video_pkg::color_t     pix,
	output logic                  blank
);
	import video_pkg::*;

	localparam int DEPTH = `VIDEO_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	vram_word_t       fifo_mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   fifo_cnt;
	logic [3:0]       bit_cnt;
	vram_word_t       shreg;
	logic             load;
	logic             pix_bit;
	pix_src_e         src;
	color_t           color;

	assign load = hvpix && gfx_en && (bit_cnt == '0);

	// storage only, pointers live below
	always_ff @(posedge clk)
	begin
		if (rd_valid)
			fifo_mem[wr_ptr] <= rd_data;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fifo_cnt   <= '0;
			credit_ret <= 1'b0;
		end
		else
		begin
			if (rd_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (load)
				rd_ptr <= rd_ptr + 1'b1;
			if (rd_valid && !load)
				fifo_cnt <= fifo_cnt + 1'b1;
			else if (load && !rd_valid)
				fifo_cnt <= fifo_cnt - 1'b1;
			// one credit back per popped word
			credit_ret <= load;
		end
	end

	// bit position within the current word, wraps every 16 pixels
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			bit_cnt <= '0;
		else if (hvpix)
			bit_cnt <= bit_cnt + 1'b1;
	end

	// msb of a fresh word goes out straight from the fifo head
	always_ff @(posedge clk)
	begin
		if (load)
			shreg <= fifo_mem[rd_ptr] << 1;
		else if (hvpix)
			shreg <= shreg << 1;
	end

	assign pix_bit = (bit_cnt == '0) ? fifo_mem[rd_ptr][15] : shreg[15];

	always_comb
	begin
		if (!hvpix)
			src = BORDER;
		else if (gfx_en && pix_bit)
			src = INK;
		else
			src = PAPER;
	end

	always_comb
	begin
		case (src)
			INK:     color = ink;
			PAPER:   color = paper;
			default: color = border;
		endcase
	end

	// output stage, lines up with the registered syncs
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pix   <= '0;
			blank <= 1'b1;
		end
		else
		begin
			pix   <= color;
			blank <= blank_raw;
		end
	end

	// fetch lead and credits must keep the fifo ahead of the shifter
	a_no_underrun: assert property (@(posedge clk) disable iff (!arst_n)
		load |-> (fifo_cnt != '0));

	// credit loop guarantees room for every returned word
	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		(rd_valid && !load) |-> (fifo_cnt < (PTR_W+1)'(DEPTH)));

endmodule

// ==== rtl/video_top.sv ====
// Video engine top level joining the timing, fetch and render blocks, the DUT of the testbench
module video_top (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  gfx_en,
	input  video_pkg::color_t     ink,
	input  video_pkg::color_t     paper,
	input  video_pkg::color_t     border,
	input  logic [8:0]            int_line,
	input  logic [8:0]            int_col,
	input  logic                  rd_valid,
	input  video_pkg::vram_word_t rd_data,
	output logic                  rd_req,
	output video_pkg::vram_addr_t rd_addr,
	output logic                  hsync,
	output logic                  vsync,
	output logic                  csync,
	output logic                  blank,
	output video_pkg::color_t     pix,
	output logic                  int_start
);

	logic       blank_raw;
	logic       hvpix;
	logic       fetch_win;
	logic       line_start;
	logic [7:0] lcount;
	logic       credit_ret;

	video_sync u_sync (
		.clk         (clk),
		.arst_n      (arst_n),
		.int_line    (int_line),
		.int_col     (int_col),
		.hsync       (hsync),
		.vsync       (vsync),
		.csync       (csync),
		.blank_raw   (blank_raw),
		.hvpix       (hvpix),
		.fetch_win   (fetch_win),
		.line_start  (line_start),
		.frame_start (),
		.int_start   (int_start),
		.lcount      (lcount)
	);

	video_fetch u_fetch (
		.clk        (clk),
		.arst_n     (arst_n),
		.gfx_en     (gfx_en),
		.fetch_win  (fetch_win),
		.line_start (line_start),
		.lcount     (lcount),
		.credit_ret (credit_ret),
		.rd_req     (rd_req),
		.rd_addr    (rd_addr)
	);

	pixel_render u_render (
		.clk        (clk),
		.arst_n     (arst_n),
		.rd_valid   (rd_valid),
		.rd_data    (rd_data),
		.hvpix      (hvpix),
		.blank_raw  (blank_raw),
		.gfx_en     (gfx_en),
		.ink        (ink),
		.paper      (paper),
		.border     (border),
		.credit_ret (credit_ret),
		.pix        (pix),
		.blank      (blank)
	);

endmodule

// ==== dv/video_tb.sv ====
// Testbench for the video engine: reads tests from the stimulus file, models memory, checks outputs
`include "video_defs.svh"

module video_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import video_pkg::*;

	localparam int FRAME_CLKS    = `VIDEO_HPERIOD * `VIDEO_VPERIOD;
	localparam int ERR_PRINT_MAX = 40;

	logic       clk;
	logic       arst_n;
	logic       gfx_en;
	color_t     ink;
	color_t     paper;
	color_t     border;
	logic [8:0] int_line;
	logic [8:0] int_col;
	logic       rd_valid;
	vram_word_t rd_data;
	logic       rd_req;
	vram_addr_t rd_addr;
	logic       hsync;
	logic       vsync;
	logic       csync;
	logic       blank;
	color_t     pix;
	logic       int_start;

	// test table
	string      t_name[$];
	color_t     t_ink[$];
	color_t     t_paper[$];
	color_t     t_border[$];
	logic       t_gfx[$];
	logic [8:0] t_line[$];
	logic [8:0] t_col[$];
	vram_word_t t_pat[$];
	int         t_frames[$];
	int         t_reqs[$];

	string      cur_name;
	vram_word_t cur_pat;
	int         cur_reqs;
	int         err_test;
	int         err_total;
	int         tests_passed;
	int         watch_clks;
	int         frames_sum;

	// raster position that the registered outputs currently show
	int         pos_h;
	int         pos_v;
	logic       h_locked;
	logic       v_locked;
	logic       full_frame;
	logic       prev_hsync;
	logic       prev_vsync;
	int         line_reqs;
	int         frame_reqs;
	int         int_count;
	int         frames_done;

	// memory model state
	logic [31:0] rng;
	int          cycle;
	int          due;
	int          last_due;
	int          outstanding;
	int          due_q[$];
	vram_word_t  data_q[$];

	video_top UUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.gfx_en    (gfx_en),
		.ink       (ink),
		.paper     (paper),
		.border    (border),
		.int_line  (int_line),
		.int_col   (int_col),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data),
		.rd_req    (rd_req),
		.rd_addr   (rd_addr),
		.hsync     (hsync),
		.vsync     (vsync),
		.csync     (csync),
		.blank     (blank),
		.pix       (pix),
		.int_start (int_start)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic in_rows(input int v);
		return (v >= `VIDEO_VPIX_BEG) && (v <= `VIDEO_VPIX_END);
	endfunction

	// pixel color from the bitmap rule, word = address xor pattern
	function automatic color_t expected_pix(input int h, input int v);
		int         x;
		int         addr;
		vram_word_t w;
		pix_src_e   src;
		src = BORDER;
		if (h >= `VIDEO_HPIX_BEG && h <= `VIDEO_HPIX_END && in_rows(v))
		begin
			x    = h - `VIDEO_HPIX_BEG;
			addr = (v - `VIDEO_VPIX_BEG) * `VIDEO_WORDS_PER_LINE + x / 16;
			w    = vram_word_t'(addr) ^ cur_pat;
			src  = (gfx_en && w[15 - x % 16]) ? INK : PAPER;
		end
		case (src)
			INK:     return ink;
			PAPER:   return paper;
			default: return border;
		endcase
	endfunction

	task automatic log_error(input string msg);
		err_test++;
		err_total++;
		if (err_test <= ERR_PRINT_MAX)
			$display("%s", msg);
	endtask

	task automatic check_color(input string what, input color_t exp, input color_t act);
		if (act !== exp)
			log_error($sformatf("[FAIL] %s %s at line %0d col %0d: expected %h, actual %h",
				cur_name, what, pos_v, pos_h, exp, act));
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp)
			log_error($sformatf("[FAIL] %s %s at line %0d col %0d: expected %b, actual %b",
				cur_name, what, pos_v, pos_h, exp, act));
	endtask

	task automatic check_addr(input string what, input vram_addr_t exp, input vram_addr_t act);
		if (act !== exp)
			log_error($sformatf("[FAIL] %s %s at line %0d col %0d: expected %h, actual %h",
				cur_name, what, pos_v, pos_h, exp, act));
	endtask

	task automatic check_count(input string what, input int exp, input int act);
		if (act != exp)
			log_error($sformatf("[FAIL] %s %s at line %0d: expected %0d, actual %0d",
				cur_name, what, pos_v, exp, act));
	endtask

	task automatic end_of_line();
		if (v_locked)
		begin
			check_count("requests per line",
				(gfx_en && in_rows(pos_v)) ? `VIDEO_WORDS_PER_LINE : 0, line_reqs);
			if (pos_v == `VIDEO_VPERIOD - 1)
			begin
				check_count("requests per frame", cur_reqs, frame_reqs);
				// first frame is seen only from vsync on
				if (full_frame)
					check_count("interrupts per frame", 1, int_count);
				frame_reqs  = 0;
				int_count   = 0;
				full_frame  = 1'b1;
				frames_done++;
				pos_v = 0;
			end
			else
				pos_v++;
		end
		line_reqs = 0;
	endtask

	// lock onto the first falling hsync and vsync, then free-run
	task automatic track_position();
		if (h_locked)
		begin
			if (pos_h == `VIDEO_HPERIOD - 1)
			begin
				end_of_line();
				pos_h = 0;
			end
			else
				pos_h++;
		end
		else if (prev_hsync && !hsync)
		begin
			pos_h    = `VIDEO_HSYNC_BEG;
			h_locked = 1'b1;
		end
		if (h_locked && !v_locked && prev_vsync && !vsync)
		begin
			if (pos_h != 0)
				log_error($sformatf("test %s: vsync fell at column %0d, not at a line start",
					cur_name, pos_h));
			pos_v      = `VIDEO_VSYNC_BEG;
			v_locked   = 1'b1;
			line_reqs  = 0;
			frame_reqs = 0;
			int_count  = 0;
		end
	endtask

	task automatic request_seen();
		int row;
		row = pos_v - `VIDEO_VPIX_BEG;
		if (!gfx_en)
			log_error($sformatf("test %s: rd_req at line %0d col %0d with graphics disabled",
				cur_name, pos_v, pos_h));
		else if (!in_rows(pos_v) || pos_h < `VIDEO_HPIX_BEG - `VIDEO_FETCH_LEAD ||
			pos_h > `VIDEO_HPIX_END)
			log_error($sformatf("test %s: rd_req outside the fetch window at line %0d col %0d",
				cur_name, pos_v, pos_h));
		else
			check_addr("rd_addr", vram_addr_t'(row * `VIDEO_WORDS_PER_LINE + line_reqs), rd_addr);
		line_reqs++;
		frame_reqs++;
	endtask

	task automatic compare_outputs();
		logic hs;
		logic vs;
		logic exp_int;
		int   nh;
		int   nv;
		hs = (pos_h >= `VIDEO_HSYNC_BEG) && (pos_h <= `VIDEO_HSYNC_END);
		vs = (pos_v >= `VIDEO_VSYNC_BEG) && (pos_v <= `VIDEO_VSYNC_END);
		check_bit("hsync", !hs, hsync);
		check_bit("vsync", !vs, vsync);
		check_bit("csync", !(hs ^ vs), csync);
		check_bit("blank", (pos_h <= `VIDEO_HBLNK_END) || (pos_v <= `VIDEO_VBLNK_END), blank);
		check_color("pix", expected_pix(pos_h, pos_v), pix);
		// int_start is combinational, so it belongs to the next count
		nh = (pos_h + 1) % `VIDEO_HPERIOD;
		nv = (nh == 0) ? (pos_v + 1) % `VIDEO_VPERIOD : pos_v;
		exp_int = (nh == int'(int_col)) && (nv == int'(int_line));
		check_bit("int_start", exp_int, int_start);
		if (int_start)
			int_count++;
		if (rd_req)
			request_seen();
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk)
	begin
		if (!arst_n)
		begin
			h_locked    = 1'b0;
			v_locked    = 1'b0;
			full_frame  = 1'b0;
			frames_done = 0;
			line_reqs   = 0;
		end
		else
		begin
			track_position();
			if (v_locked)
				compare_outputs();
		end
		prev_hsync = hsync;
		prev_vsync = vsync;
	end

	// memory model, answers in order 1 to 8 clocks after the request
	always @(posedge clk)
	begin
		#5;
		cycle++;
		if (!arst_n)
		begin
			due_q.delete();
			data_q.delete();
			last_due    = 0;
			outstanding = 0;
			rd_valid    = 1'b0;
		end
		else
		begin
			if (rd_req)
			begin
				rng = xorshift(rng);
				due = cycle + int'(rng[2:0]) + 1;
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				due_q.push_back(due);
				data_q.push_back(vram_word_t'(rd_addr) ^ cur_pat);
				outstanding++;
				if (outstanding > `VIDEO_FIFO_DEPTH)
					log_error($sformatf("test %s: %0d reads outstanding, more than the credits",
						cur_name, outstanding));
			end
			rd_valid = 1'b0;
			if (due_q.size() > 0 && due_q[0] == cycle)
			begin
				rd_valid = 1'b1;
				rd_data  = data_q.pop_front();
				void'(due_q.pop_front());
				outstanding--;
			end
		end
	end

	task automatic read_tests();
		int              fd;
		int              n;
		string           line;
		logic [8*24-1:0] name_buf;
		color_t          c_ink;
		color_t          c_paper;
		color_t          c_border;
		logic            en;
		logic [8:0]      il;
		logic [8:0]      ic;
		vram_word_t      pat;
		int              frames;
		int              reqs;
		fd = $fopen("dv/video_stimulus.txt", "r");
		if (fd == 0)
		begin
			log_error("could not open the stimulus file dv/video_stimulus.txt");
			return;
		end
		while (!$feof(fd))
		begin
			n = $fgets(line, fd);
			if (n <= 0 || line.substr(0, 0) == "#")
				continue;
			n = $sscanf(line, "%s %h %h %h %d %d %d %h %d %d", name_buf, c_ink, c_paper,
				c_border, en, il, ic, pat, frames, reqs);
			if (n == 10)
			begin
				t_name.push_back($sformatf("%0s", name_buf));
				t_ink.push_back(c_ink);
				t_paper.push_back(c_paper);
				t_border.push_back(c_border);
				t_gfx.push_back(en);
				t_line.push_back(il);
				t_col.push_back(ic);
				t_pat.push_back(pat);
				t_frames.push_back(frames);
				t_reqs.push_back(reqs);
			end
			else if (n > 0)
				log_error($sformatf("malformed stimulus line: %s", line));
		end
		$fclose(fd);
		if (t_name.size() == 0)
			log_error("the stimulus file holds no tests");
	endtask

	// fresh reset per test, then run until enough frames wrapped
	task automatic run_test(input int i);
		@(posedge clk);
		#5;
		arst_n   = 1'b0;
		cur_name = t_name[i];
		cur_pat  = t_pat[i];
		cur_reqs = t_reqs[i];
		err_test = 0;
		gfx_en   = t_gfx[i];
		ink      = t_ink[i];
		paper    = t_paper[i];
		border   = t_border[i];
		int_line = t_line[i];
		int_col  = t_col[i];
		repeat (2) @(posedge clk);
		#5;
		arst_n = 1'b1;
		while (frames_done < t_frames[i])
			@(posedge clk);
		if (err_test == 0)
		begin
			tests_passed++;
			$display("test %s passed", cur_name);
		end
		else
			$display("test %s failed with %0d mismatches", cur_name, err_test);
	endtask

	initial
	begin
		clk          = 1'b0;
		arst_n       = 1'b0;
		gfx_en       = 1'b0;
		ink          = '0;
		paper        = '0;
		border       = '0;
		int_line     = '0;
		int_col      = '0;
		rd_valid     = 1'b0;
		rd_data      = '0;
		rng          = 32'hf26b;
		cycle        = 0;
		last_due     = 0;
		outstanding  = 0;
		err_test     = 0;
		err_total    = 0;
		tests_passed = 0;
		cur_name     = "setup";
		cur_pat      = '0;
		cur_reqs     = 0;
		prev_hsync   = 1'b1;
		prev_vsync   = 1'b1;
		read_tests();
		frames_sum = 0;
		foreach (t_frames[i])
			frames_sum += t_frames[i];
		// one spare frame per test covers reset and sync lock
		watch_clks = (frames_sum + t_name.size()) * FRAME_CLKS + 1000;
		foreach (t_name[i])
			run_test(i);
		$display("summary: %0d of %0d tests passed, %0d mismatches", tests_passed,
			t_name.size(), err_total);
		if (err_total == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		wait (watch_clks > 0);
		repeat (watch_clks) @(posedge clk);
		$display("timeout: tests did not finish within %0d clocks", watch_clks);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== dv/video_stimulus.txt ====
# name ink paper border gfx_en int_line int_col pattern frames reqs_per_frame
# colors and pattern in hex, other fields decimal; reqs_per_frame is 3072 with graphics on
basic     f 1 4 1 100 200 0000 2 3072
inverse   2 e 7 1 0   5   ffff 2 3072
checker   a 5 3 1 319 447 5a5a 1 3072
no_gfx    c 9 6 0 8   10  a5a5 1 0
edge_int  7 0 b 1 271 391 1234 1 3072
dense     3 d 1 1 40  136 c3e1 2 3072

// ==== sim.f ====
+incdir+common
common/video_pkg.sv
rtl/video_sync.sv
rtl/video_fetch.sv
rtl/pixel_render.sv
rtl/video_top.sv
dv/video_tb.sv

// ==== Makefile ====
# Verilator build and run for the video engine testbench

VERILATOR  ?= verilator
TOP        ?= video_tb
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
TIMESCALE  ?= 1ns/1ns
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
